// File: src.f
common/anc_pkg.sv
writer/magnet_decoder.sv
writer/code_capture.sv
writer/char_fifo.sv
writer/magnet_sequencer.sv
hw/anc_writer_top.sv
verification/anc_writer_checker.sv
verification/anc_writer_tb.sv

// File: Makefile
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := anc_writer_tb
FILELIST   := src.f
OBJ_DIR    := obj_dir
BIN        := $(OBJ_DIR)/V$(TOP)
LOG        := sim.log
FAIL_MSG   := Simulation failed
SHELL      := /bin/bash

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG); test $${PIPESTATUS[0]} -eq 0
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run FAILED, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/anc_writer_tb.sv
// testbench for the coupler writer path, sends hex and alphanumeric characters and checks the strikes
`timescale 1ns/10ps

module anc_writer_tb;

    localparam int n_chars    = 47;                 // 18 hex, 19 alphanumeric, 10 in the burst
    localparam int max_cycles = n_chars * 400 + 1000;

    // magnet per code; -1 is no character, 64 + control magnet code for cr, tab and space
    localparam int hex_tab [32] = '{
        67, 43, 65, 66, -1, -1, 36, -1, 67, 43, 65, 66, -1, -1, 36, -1,
        35, 39, 3, 7, 11, 15, 19, 23, 27, 31, 25, 16, 5, 8, 21, 4
    };
    localparam int an_tab [64] = '{
        35, 39, 3, 7, 11, 15, 19, 23, 27, 31, -1, 15, -1, -1, -1, -1,
        3, 2, 20, 12, 10, 9, 14, 18, 22, 29, 42, 36, 35, 38, 41, -1,
        43, 26, 30, 34, 28, 24, 33, 37, 1, 13, 65, 11, 43, 66, -1, -1,
        -1, 40, 6, 17, 25, 16, 5, 8, 21, 4, -1, 32, 31, 67, -1, -1
    };
    localparam logic [5:0] hex_extras [6] = '{6'd0, 6'd1, 6'd2, 6'd3, 6'd6, 6'd4};   // last unused
    localparam logic [5:0] an_specials [7] = '{6'd49, 6'd11, 6'd43, 6'd60, 6'd16, 6'd28, 6'd44};

    logic               clk;
    logic               rst_n;
    logic               tick_ms;
    logic               an_mode;
    logic               type_on;
    logic               exc;
    anc_pkg::lev_t      lev;
    logic               ready;
    logic               overrun;
    logic               mag_fire;
    anc_pkg::mag_num_t  mag_num;
    anc_pkg::ctrl_mag_t mag_ctrl;
    logic               mag_shift;

    logic [6:0] exp_q [$];                          // accepted characters, {an, code}
    int         errors = 0;
    int         n_checks = 0;

    anc_writer_top #(
        .fifo_depth      (anc_pkg::default_fifo_depth),
        .shift_settle_ms (2),
        .strike_ms       (2)
    ) dut (
        .clk, .rst_n, .tick_ms, .an_mode, .type_on, .exc, .lev,
        .ready, .overrun, .mag_fire, .mag_num, .mag_ctrl, .mag_shift
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        int phase;
        phase = 0;
        tick_ms = 1'b0;
        forever begin
            @(negedge clk);
            tick_ms = (phase == 7);                 // one pulse every 8 cycles
            phase = (phase + 1) % 8;
        end
    end

    // {valid, shift, ctrl[1:0], num[5:0]}
    function automatic logic [9:0] ref_decode(input logic an, input logic [5:0] code);
        int   e;
        logic shift;
        e = an ? an_tab[code] : hex_tab[code[4:0]];
        shift = an && (code inside {6'd11, 6'd16, 6'd28, 6'd43, 6'd44, 6'd49, 6'd60});
        if (e < 0) return 10'd0;
        if (e >= 64) return {1'b1, 1'b0, 2'(e - 64), 6'd0};
        return {1'b1, shift, 2'd0, 6'(e)};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
        n_checks++;
        if (got !== want) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
            errors++;
        end
    endtask

    // ------------------------------
    // send side
    // ------------------------------
    task automatic strobe_frame(input anc_pkg::lev_t l, inout bit ok);
        lev = l;
        exc = 1'b1;
        @(negedge clk);
        if (!ready) ok = 1'b0;                      // ready as seen by the detecting edge
        exc = 1'b0;
        @(negedge clk);
    endtask

    task automatic send_char(input logic an, input logic [5:0] code, input bit wait_rdy,
                             output bit ok);
        logic [9:0] d;
        while (wait_rdy && !ready) @(negedge clk);
        ok = 1'b1;
        an_mode = an;
        if (an) begin
            strobe_frame({3'b100, code[5:4]}, ok);  // upper bits frame
        end
        strobe_frame(an ? {1'b0, code[3:0]} : code[4:0], ok);
        d = ref_decode(an, code);
        if (ok && d[9]) exp_q.push_back({an, code});
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0 || mag_fire || mag_shift) @(negedge clk);
    endtask

    // ------------------------------
    // strike comparison
    // ------------------------------
    initial begin
        logic       fire_prev;
        logic       shift_prev;
        logic [6:0] ch;
        logic [9:0] want;
        fire_prev = 1'b0;
        shift_prev = 1'b0;
        forever begin
            @(negedge clk);
            if (mag_fire && !fire_prev) begin
                if (exp_q.size() == 0) begin
                    $display("strike at %0t with no character pending", $time);
                    errors++;
                end else begin
                    ch = exp_q.pop_front();
                    want = ref_decode(ch[6], ch[5:0]);
                    check_value("mag_ctrl", 32'(mag_ctrl), 32'(want[7:6]));
                    if (want[7:6] == 2'd0) check_value("mag_num", 32'(mag_num), 32'(want[5:0]));
                    check_value("mag_shift", 32'(mag_shift), 32'(want[8]));
                    if (want[8]) check_value("mag_shift", 32'(shift_prev), 32'd1);  // leads fire
                end
            end
            fire_prev = mag_fire;
            shift_prev = mag_shift;
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d strikes still expected", cycles, exp_q.size());
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int         code;
        int         dropped;
        int         before_drop;
        bit         ok;
        logic [9:0] d;
        void'($urandom(32'h9d62));
        rst_n = 1'b0;
        an_mode = 1'b0;
        type_on = 1'b0;
        exc = 1'b0;
        lev = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("ready", 32'(ready), 32'd1);
        check_value("mag_fire", 32'(mag_fire), 32'd0);
        check_value("mag_shift", 32'(mag_shift), 32'd0);
        check_value("overrun", 32'(overrun), 32'd0);
        check_value("mag_ctrl", 32'(mag_ctrl), 32'(anc_pkg::ctrl_none));
        type_on = 1'b1;

        repeat (12) send_char(1'b0, 6'($urandom_range(16, 31)), 1'b1, ok);   // digits, u..z
        foreach (hex_extras[i]) send_char(1'b0, hex_extras[i], 1'b1, ok);
        repeat (12) begin
            do begin
                code = $urandom_range(0, 63);
                d = ref_decode(1'b1, 6'(code));
            end while (!d[9] || d[8]);              // plain characters only
            send_char(1'b1, 6'(code), 1'b1, ok);
        end
        foreach (an_specials[i]) send_char(1'b1, an_specials[i], 1'b1, ok);
        wait_idle();
        check_value("overrun", 32'(overrun), 32'd0);

        // back-to-back strobes until the credits run out
        dropped = 0;
        before_drop = 0;
        for (int i = 0; i < 10; i++) begin
            send_char(1'b0, 6'($urandom_range(16, 31)), 1'b0, ok);
            if (!ok) dropped++;
            else if (dropped == 0) before_drop++;
        end
        check_value("ready", 32'(dropped > 0), 32'd1);
        check_value("ready", 32'(before_drop <= 5), 32'd1);   // 4 buffered plus one popped
        wait_idle();
        check_value("overrun", 32'(overrun), 32'd1);

        $display("checks run: %0d, errors: %0d", n_checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verification/anc_writer_checker.sv
// assertion checker bound onto the writer top level, watches the magnet outputs and ready
`timescale 1ns/10ps

module anc_writer_checker (
    input logic               clk,
    input logic               rst_n,
    input logic               ready,
    input logic               mag_fire,
    input anc_pkg::mag_num_t  mag_num,
    input anc_pkg::ctrl_mag_t mag_ctrl,
    input logic               mag_shift
);

    a_fire_num: assert property (@(posedge clk) disable iff (!rst_n)
        mag_fire |-> (mag_num <= 6'd43))            // typebars 0..43 only
        else $error("magnet number out of range during strike");

    a_ctrl_fire: assert property (@(posedge clk) disable iff (!rst_n)
        (mag_ctrl != anc_pkg::ctrl_none) |-> (mag_fire && mag_num == '0))
        else $error("control magnet active outside a strike or with a typebar");

    a_shift_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mag_fire && mag_shift) |=> (!mag_fire || mag_shift))
        else $error("shift magnet dropped during strike");

    a_num_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mag_fire |=> (!mag_fire || $stable(mag_num)))
        else $error("magnet number changed during strike");

    a_ready_reset: assert property (@(posedge clk) $rose(rst_n) |-> ready)
        else $error("ready low in first cycle after reset");

endmodule

bind anc_writer_top anc_writer_checker u_checker (
    .clk, .rst_n, .ready, .mag_fire, .mag_num, .mag_ctrl, .mag_shift
);

// File: hw/anc_writer_top.sv
// top of the coupler output path: capture, character buffer and magnet sequencer
`timescale 1ns/10ps

module anc_writer_top #(
    parameter int fifo_depth      = anc_pkg::default_fifo_depth,
    parameter int shift_settle_ms = 15,
    parameter int strike_ms       = 10
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tick_ms,
    input  logic               an_mode,
    input  logic               type_on,
    input  logic               exc,
    input  anc_pkg::lev_t      lev,
    output logic               ready,
    output logic               overrun,
    output logic               mag_fire,
    output anc_pkg::mag_num_t  mag_num,
    output anc_pkg::ctrl_mag_t mag_ctrl,
    output logic               mag_shift
);

    logic           push;
    anc_pkg::char_t push_char;
    logic           credit;
    logic           pop;
    logic           char_avail;
    anc_pkg::char_t head_char;

    code_capture #(
        .fifo_depth (fifo_depth)
    ) u_capture (
        .clk, .rst_n, .an_mode, .type_on, .exc, .lev, .credit,
        .push, .push_char, .ready, .overrun
    );

    char_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk, .rst_n, .push, .push_char, .pop,
        .char_avail, .head_char, .credit
    );

    magnet_sequencer #(
        .shift_settle_ms (shift_settle_ms),
        .strike_ms       (strike_ms)
    ) u_seq (
        .clk, .rst_n, .tick_ms, .char_avail, .head_char,
        .pop, .mag_fire, .mag_num, .mag_ctrl, .mag_shift
    );

endmodule

// File: writer/magnet_sequencer.sv
// consumer side: pops characters and drives shift, strike and release of the typewriter magnets
`timescale 1ns/10ps

module magnet_sequencer #(
    parameter int shift_settle_ms = 15,
    parameter int strike_ms       = 10
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tick_ms,
    input  logic               char_avail,
    input  anc_pkg::char_t     head_char,
    output logic               pop,
    output logic               mag_fire,
    output anc_pkg::mag_num_t  mag_num,
    output anc_pkg::ctrl_mag_t mag_ctrl,
    output logic               mag_shift
);

    typedef enum logic [1:0] {
        st_idle,
        st_shift_settle,
        st_strike,
        st_release
    } state_t;

    localparam anc_pkg::ms_count_t settle_last = anc_pkg::ms_count_t'(shift_settle_ms - 1);
    localparam anc_pkg::ms_count_t strike_last = anc_pkg::ms_count_t'(strike_ms - 1);

    state_t             state;
    anc_pkg::ms_count_t timer;                      // tick_ms pulses in this state
    anc_pkg::char_t     char_q;
    logic               dec_valid;
    anc_pkg::mag_num_t  dec_num;
    anc_pkg::ctrl_mag_t dec_ctrl;
    logic               dec_shift;

    magnet_decoder u_dec (
        .code       (char_q),
        .valid      (dec_valid),
        .mag_num    (dec_num),
        .mag_ctrl   (dec_ctrl),
        .need_shift (dec_shift)
    );

    assign pop       = (state == st_idle) & char_avail;
    assign mag_fire  = (state == st_strike);
    assign mag_num   = mag_fire ? dec_num : '0;
    assign mag_ctrl  = mag_fire ? dec_ctrl : anc_pkg::ctrl_none;
    assign mag_shift = dec_shift & ((state == st_shift_settle) | (state == st_strike));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            timer <= '0;
        end else begin
            case (state)
                st_idle: begin
                    timer <= '0;
                    if (char_avail) begin
                        state <= st_shift_settle;
                    end
                end
                st_shift_settle: begin
                    if (!dec_valid) begin
                        state <= st_idle;           // unknown code, dropped
                    end else if (!dec_shift) begin
                        state <= st_strike;
                    end else if (tick_ms) begin
                        if (timer == settle_last) begin
                            state <= st_strike;
                            timer <= '0;
                        end else begin
                            timer <= timer + 1'b1;
                        end
                    end
                end
                st_strike: begin
                    if (tick_ms) begin
                        if (timer == strike_last) begin
                            state <= st_release;
                            timer <= '0;
                        end else begin
                            timer <= timer + 1'b1;
                        end
                    end
                end
                st_release: begin
                    if (tick_ms) begin
                        state <= st_idle;           // one tick with all magnets off
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            char_q <= head_char;
        end
    end

endmodule

// File: writer/char_fifo.sv
// character buffer between capture and sequencer, hands back one credit per character popped
`timescale 1ns/10ps

module char_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           push,
    input  anc_pkg::char_t push_char,
    input  logic           pop,
    output logic           char_avail,
    output anc_pkg::char_t head_char,
    output logic           credit
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    anc_pkg::char_t   mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_pop;

    // wraps at fifo_depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(fifo_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign char_avail = (count != '0);
    assign head_char  = mem[rd_ptr];
    assign do_pop     = pop & char_avail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count  <= count + cnt_w'(push) - cnt_w'(do_pop);
            credit <= do_pop;                       // back to the producer next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_char;
        end
    end

endmodule

// File: writer/code_capture.sv
// producer side of the writer path: detects execute strobes and builds characters for the buffer
`timescale 1ns/10ps

module code_capture #(
    parameter int fifo_depth = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           an_mode,
    input  logic           type_on,
    input  logic           exc,
    input  anc_pkg::lev_t  lev,
    input  logic           credit,
    output logic           push,
    output anc_pkg::char_t push_char,
    output logic           ready,
    output logic           overrun
);

    localparam int cnt_w = $clog2(fifo_depth + 1);

    logic             exc_q;        // sampled execute line
    logic             exc_qq;       // previous sample, for edge detect
    logic             type_q;
    logic             an_q;
    anc_pkg::lev_t    lev_q;
    logic [1:0]       hi_bits;      // char bits 6 and 5 from the first an frame
    logic [cnt_w-1:0] credits;
    logic             strobe;
    logic             first_frame;
    logic             spend;

    assign strobe      = exc_q & ~exc_qq & type_q;
    assign first_frame = an_q & lev_q[4];           // level 5 marks the upper-bits frame
    assign spend       = strobe & ready & ~first_frame;
    assign ready       = (credits != '0);

    // ------------------------------
    // sampling, credits, overrun
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exc_q   <= 1'b0;
            exc_qq  <= 1'b0;
            type_q  <= 1'b0;
            an_q    <= 1'b0;
            credits <= cnt_w'(fifo_depth);
            push    <= 1'b0;
            overrun <= 1'b0;
        end else begin
            exc_q   <= exc;
            exc_qq  <= exc_q;
            type_q  <= type_on;
            an_q    <= an_mode;
            credits <= credits - cnt_w'(spend) + cnt_w'(credit);
            push    <= spend;                       // one push per spent credit
            if (strobe && !ready) begin
                overrun <= 1'b1;                    // sticky, strobe is lost
            end
        end
    end

    // ------------------------------
    // character assembly
    // ------------------------------
    always_ff @(posedge clk) begin
        lev_q <= lev;
        if (strobe && ready && first_frame) begin
            hi_bits <= {lev_q[1], lev_q[0]};        // level 2 -> bit 6, level 1 -> bit 5
        end
        if (spend) begin
            push_char <= an_q ? {1'b1, hi_bits, lev_q[3:0]} : {2'b00, lev_q};
        end
    end

endmodule

// File: writer/magnet_decoder.sv
// g-15 character code to ibm typewriter magnet table, hex and alphanumeric halves
`timescale 1ns/10ps

module magnet_decoder (
    input  anc_pkg::char_t     code,
    output logic               valid,
    output anc_pkg::mag_num_t  mag_num,
    output anc_pkg::ctrl_mag_t mag_ctrl,
    output logic               need_shift
);

    // digit typebars indexed by digit value
    localparam anc_pkg::mag_num_t digit_mag [10] = '{
        6'd35, 6'd39, 6'd3, 6'd7, 6'd11, 6'd15, 6'd19, 6'd23, 6'd27, 6'd31
    };

    logic       an;
    logic [5:0] c;

    assign an = code[anc_pkg::char_mode_bit];
    assign c  = code[5:0];

    always_comb begin
        valid    = 1'b1;
        mag_num  = '0;                              // only meaningful with ctrl_none
        mag_ctrl = anc_pkg::ctrl_none;
        if (!an) begin
            case (c[4:0]) inside
                5'b0?000: mag_ctrl = anc_pkg::ctrl_space;
                5'b0?001: mag_num = 6'd43;          // -
                5'b0?010: mag_ctrl = anc_pkg::ctrl_cr;
                5'b0?011: mag_ctrl = anc_pkg::ctrl_tab;
                5'b0?110: mag_num = 6'd36;          // .
                [5'b10000:5'b11001]: mag_num = digit_mag[c[3:0]];
                5'b11010: mag_num = 6'd25;          // u
                5'b11011: mag_num = 6'd16;          // v
                5'b11100: mag_num = 6'd5;           // w
                5'b11101: mag_num = 6'd8;           // x
                5'b11110: mag_num = 6'd21;          // y
                5'b11111: mag_num = 6'd4;           // z
                default: valid = 1'b0;
            endcase
        end else begin
            case (c) inside
                [6'b000000:6'b001001]: mag_num = digit_mag[c[3:0]];
                6'b001011: mag_num = 6'd15;         // =
                6'b010000: mag_num = 6'd3;          // +
                6'b010001: mag_num = 6'd2;          // a
                6'b010010: mag_num = 6'd20;         // b
                6'b010011: mag_num = 6'd12;         // c
                6'b010100: mag_num = 6'd10;         // d
                6'b010101: mag_num = 6'd9;          // e
                6'b010110: mag_num = 6'd14;         // f
                6'b010111: mag_num = 6'd18;         // g
                6'b011000: mag_num = 6'd22;         // h
                6'b011001: mag_num = 6'd29;         // i
                6'b011010: mag_num = 6'd42;         // <
                6'b011011: mag_num = 6'd36;         // .
                6'b011100: mag_num = 6'd35;         // )
                6'b011101: mag_num = 6'd38;         // :
                6'b011110: mag_num = 6'd41;         // and / or
                6'b100000: mag_num = 6'd43;         // -
                6'b100001: mag_num = 6'd26;         // j
                6'b100010: mag_num = 6'd30;         // k
                6'b100011: mag_num = 6'd34;         // l
                6'b100100: mag_num = 6'd28;         // m
                6'b100101: mag_num = 6'd24;         // n
                6'b100110: mag_num = 6'd33;         // o
                6'b100111: mag_num = 6'd37;         // p
                6'b101000: mag_num = 6'd1;          // q
                6'b101001: mag_num = 6'd13;         // r
                6'b101010: mag_ctrl = anc_pkg::ctrl_cr;
                6'b101011: mag_num = 6'd11;         // $
                6'b101100: mag_num = 6'd43;         // *
                6'b101101: mag_ctrl = anc_pkg::ctrl_tab;
                6'b110001: mag_num = 6'd40;         // /
                6'b110010: mag_num = 6'd6;          // s
                6'b110011: mag_num = 6'd17;         // t
                6'b110100: mag_num = 6'd25;         // u
                6'b110101: mag_num = 6'd16;         // v
                6'b110110: mag_num = 6'd5;          // w
                6'b110111: mag_num = 6'd8;          // x, fills the gap after w
                6'b111000: mag_num = 6'd21;         // y
                6'b111001: mag_num = 6'd4;          // z
                6'b111011: mag_num = 6'd32;         // ,
                6'b111100: mag_num = 6'd31;         // (
                6'b111101: mag_ctrl = anc_pkg::ctrl_space;
                default: valid = 1'b0;
            endcase
        end
    end

    // Specials sit on the other case of a digit or symbol typebar,
    // so the carriage has to shift before the strike.
    assign need_shift = an & (c inside {6'b110001, 6'b001011, 6'b101011, 6'b111100,
                                        6'b010000, 6'b011100, 6'b101100});

endmodule

// File: common/anc_pkg.sv
// shared widths, types and control-magnet codes for the coupler writer path and its testbench
package anc_pkg;

    // ------------------------------
    // g-15 side
    // ------------------------------
    typedef logic [4:0] lev_t;          // levels 1..5, bit 0 is level 1

    // assembled character, bit 6 set when it came in alphanumeric mode
    typedef logic [6:0] char_t;
    parameter int char_mode_bit = 6;    // mode flag position in char_t

    // ------------------------------
    // typewriter side
    // ------------------------------
    typedef logic [5:0] mag_num_t;      // ibm typebar magnet 0..43

    // control magnet fired instead of a typebar
    typedef enum logic [1:0] {
        ctrl_none,
        ctrl_cr,
        ctrl_tab,
        ctrl_space
    } ctrl_mag_t;

    typedef logic [5:0] ms_count_t;     // sequencer millisecond timers

    parameter int default_fifo_depth = 4;   // buffer depth, also initial credits

endpackage
